//--- Bender.yml
package:
  name: mini_core

export_include_dirs:
  - include

sources:
  - design/core_pkg.sv
  - design/ctrl_pkg.sv
  - design/mini_core_ctrl.sv
  - design/mini_core_fetch.sv
  - design/mini_core_regfile.sv
  - design/mini_core_execute.sv
  - design/mini_core_writeback.sv
  - design/mini_core.sv
  - target: simulation
    files:
      - verification/mini_core_tb.sv

//--- design/core_pkg.sv
package core_pkg;

  typedef logic [31:0] word_t;
  typedef logic [4:0]  reg_addr_t;
  typedef logic [31:0] instr_t;

  ////////////////////////////////////////////////////////////////////////////
  // major opcodes
  ////////////////////////////////////////////////////////////////////////////
  localparam logic [6:0] OPC_OP     = 7'b0110011;
  localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
  localparam logic [6:0] OPC_LUI    = 7'b0110111;
  localparam logic [6:0] OPC_LOAD   = 7'b0000011;
  localparam logic [6:0] OPC_STORE  = 7'b0100011;
  localparam logic [6:0] OPC_BRANCH = 7'b1100011;
  localparam logic [6:0] OPC_JAL    = 7'b1101111;
  localparam logic [6:0] OPC_SYSTEM = 7'b1110011;

  // funct3 / funct7 / funct12 values of the supported subset
  localparam logic [2:0]  F3_ADD_SUB = 3'b000;
  localparam logic [2:0]  F3_SLT     = 3'b010;
  localparam logic [2:0]  F3_XOR     = 3'b100;
  localparam logic [2:0]  F3_OR      = 3'b110;
  localparam logic [2:0]  F3_AND     = 3'b111;
  localparam logic [2:0]  F3_WORD    = 3'b010;
  localparam logic [2:0]  F3_BEQ     = 3'b000;
  localparam logic [2:0]  F3_BNE     = 3'b001;
  localparam logic [2:0]  F3_PRIV    = 3'b000;
  localparam logic [6:0]  F7_BASE    = 7'b0000000;
  localparam logic [6:0]  F7_SUB     = 7'b0100000;
  localparam logic [11:0] F12_ECALL  = 12'h000;
  localparam logic [11:0] F12_MRET   = 12'h302;

  // addi x0, x0, 0
  localparam instr_t NOP_INSTR = 32'h0000_0013;

  localparam word_t RESET_PC    = 32'h0000_0000;
  localparam word_t TRAP_VECTOR = 32'h0000_0100;

endpackage

//--- design/ctrl_pkg.sv
package ctrl_pkg;

  // ALU function selected by the decoder
  typedef enum logic [2:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_XOR,
    ALU_SLT,
    ALU_PASS_B
  } alu_op_e;

  // source of the register write value
  typedef enum logic [1:0] {
    WB_ALU,
    WB_MEM,
    WB_LINK
  } wb_src_e;

  // machine-mode trap state
  typedef enum logic {
    ST_RUN,
    ST_TRAPPING
  } trap_state_e;

endpackage

//--- design/mini_core.sv
`timescale 1ns/1ps

module mini_core import core_pkg::*, ctrl_pkg::*; (
  input  logic      clk,
  input  logic      rst_n,
  output word_t     imem_addr,
  input  instr_t    imem_data,
  output word_t     dmem_addr,
  output word_t     dmem_wdata,
  output logic      dmem_we,
  output logic      dmem_re,
  input  word_t     dmem_rdata,
  input  logic      debug,
  input  reg_addr_t debug_addr,
  output word_t     debug_data,
  output logic      trapping
);

  instr_t    id_instr;
  word_t     id_pc, imm, pc_target, rs1_data, rs2_data;
  reg_addr_t rs1, rs2, rd, ex_rd, wb_rd;
  alu_op_e   alu_op;
  wb_src_e   wb_src, ex_wb_src;
  logic      alu_src_imm, mem_read, mem_write, reg_write;
  logic      is_branch, branch_ne, is_jal, is_ecall, is_mret;
  logic      pc_load, flush, freeze;
  logic      ex_redirect, ex_ecall, ex_mret, ex_reg_write, wb_we;
  word_t     ex_target, ex_pc, ex_result, wb_data;

  mini_core_ctrl i_ctrl (
    .clk, .rst_n, .debug, .id_instr, .ex_redirect, .ex_target, .ex_ecall, .ex_mret,
    .ex_pc, .rs1, .rs2, .rd, .imm, .alu_op, .alu_src_imm, .mem_read, .mem_write,
    .reg_write, .wb_src, .is_branch, .branch_ne, .is_jal, .is_ecall, .is_mret,
    .pc_load, .pc_target, .flush, .freeze, .trapping
  );

  mini_core_fetch i_fetch (
    .clk, .rst_n, .freeze, .flush, .pc_load, .pc_target, .imem_data,
    .imem_addr, .id_instr, .id_pc
  );

  mini_core_regfile i_regfile (
    .clk, .rst_n, .debug, .debug_addr, .rs1, .rs2, .wb_we, .wb_rd, .wb_data,
    .rs1_data, .rs2_data
  );

  mini_core_execute i_execute (
    .clk, .rst_n, .freeze, .flush, .rs1, .rs2, .rd, .imm, .alu_op, .alu_src_imm,
    .mem_read, .mem_write, .reg_write, .wb_src, .is_branch, .branch_ne, .is_jal,
    .is_ecall, .is_mret, .id_pc, .rs1_data, .rs2_data, .wb_we, .wb_rd, .wb_data,
    .ex_redirect, .ex_target, .ex_ecall, .ex_mret, .ex_pc, .ex_result, .ex_rd,
    .ex_reg_write, .ex_wb_src, .dmem_addr, .dmem_wdata, .dmem_we, .dmem_re
  );

  mini_core_writeback i_writeback (
    .clk, .rst_n, .freeze, .ex_result, .ex_rd, .ex_reg_write, .ex_wb_src,
    .dmem_rdata, .wb_we, .wb_rd, .wb_data
  );

  // debug port, address 0 shows the decode pc
  always_ff @(posedge clk) begin
    if (!rst_n || !debug) begin
      debug_data <= '0;
    end else begin
      debug_data <= (debug_addr == '0) ? id_pc : rs1_data;
    end
  end

endmodule

//--- design/mini_core_ctrl.sv
`timescale 1ns/1ps

module mini_core_ctrl import core_pkg::*, ctrl_pkg::*; (
  input  logic      clk,
  input  logic      rst_n,
  input  logic      debug,
  input  instr_t    id_instr,
  input  logic      ex_redirect,
  input  word_t     ex_target,
  input  logic      ex_ecall,
  input  logic      ex_mret,
  input  word_t     ex_pc,
  output reg_addr_t rs1,
  output reg_addr_t rs2,
  output reg_addr_t rd,
  output word_t     imm,
  output alu_op_e   alu_op,
  output logic      alu_src_imm,
  output logic      mem_read,
  output logic      mem_write,
  output logic      reg_write,
  output wb_src_e   wb_src,
  output logic      is_branch,
  output logic      branch_ne,
  output logic      is_jal,
  output logic      is_ecall,
  output logic      is_mret,
  output logic      pc_load,
  output word_t     pc_target,
  output logic      flush,
  output logic      freeze,
  output logic      trapping
);

  logic [6:0]  opcode;
  logic [2:0]  funct3;
  logic [6:0]  funct7;
  trap_state_e state_q;
  word_t       epc_q;
  logic        take_trap;
  logic        take_ret;

  assign opcode = id_instr[6:0];
  assign funct3 = id_instr[14:12];
  assign funct7 = id_instr[31:25];
  assign rs1    = id_instr[19:15];
  assign rs2    = id_instr[24:20];
  assign rd     = id_instr[11:7];

  ////////////////////////////////////////////////////////////////////////////
  // instruction decoder
  ////////////////////////////////////////////////////////////////////////////
  always_comb begin
    imm         = {{20{id_instr[31]}}, id_instr[31:20]};
    alu_op      = ALU_ADD;
    alu_src_imm = 1'b0;
    mem_read    = 1'b0;
    mem_write   = 1'b0;
    reg_write   = 1'b0;
    wb_src      = WB_ALU;
    is_branch   = 1'b0;
    branch_ne   = 1'b0;
    is_jal      = 1'b0;
    is_ecall    = 1'b0;
    is_mret     = 1'b0;
    case (opcode)
      OPC_OP: begin
        if (funct7 == F7_BASE || (funct7 == F7_SUB && funct3 == F3_ADD_SUB)) begin
          reg_write = 1'b1;
          case (funct3)
            F3_ADD_SUB: alu_op = (funct7 == F7_SUB) ? ALU_SUB : ALU_ADD;
            F3_SLT:     alu_op = ALU_SLT;
            F3_XOR:     alu_op = ALU_XOR;
            F3_OR:      alu_op = ALU_OR;
            F3_AND:     alu_op = ALU_AND;
            default:    reg_write = 1'b0;
          endcase
        end
      end
      // only addi of the immediate group
      OPC_OP_IMM: begin
        alu_src_imm = 1'b1;
        reg_write   = (funct3 == F3_ADD_SUB);
      end
      OPC_LUI: begin
        imm         = {id_instr[31:12], 12'b0};
        alu_op      = ALU_PASS_B;
        alu_src_imm = 1'b1;
        reg_write   = 1'b1;
      end
      OPC_LOAD: begin
        alu_src_imm = 1'b1;
        mem_read    = (funct3 == F3_WORD);
        reg_write   = (funct3 == F3_WORD);
        wb_src      = WB_MEM;
      end
      OPC_STORE: begin
        imm         = {{20{id_instr[31]}}, id_instr[31:25], id_instr[11:7]};
        alu_src_imm = 1'b1;
        mem_write   = (funct3 == F3_WORD);
      end
      OPC_BRANCH: begin
        imm = {{19{id_instr[31]}}, id_instr[31], id_instr[7], id_instr[30:25],
               id_instr[11:8], 1'b0};
        is_branch = (funct3 == F3_BEQ) || (funct3 == F3_BNE);
        branch_ne = (funct3 == F3_BNE);
      end
      OPC_JAL: begin
        imm = {{11{id_instr[31]}}, id_instr[31], id_instr[19:12], id_instr[20],
               id_instr[30:21], 1'b0};
        is_jal    = 1'b1;
        reg_write = 1'b1;
        wb_src    = WB_LINK;
      end
      OPC_SYSTEM: begin
        is_ecall = (funct3 == F3_PRIV) && (id_instr[31:20] == F12_ECALL);
        is_mret  = (funct3 == F3_PRIV) && (id_instr[31:20] == F12_MRET);
      end
      default: ;
    endcase
  end

  ////////////////////////////////////////////////////////////////////////////
  // redirect, trap entry and return
  ////////////////////////////////////////////////////////////////////////////
  assign freeze    = debug;
  assign trapping  = (state_q == ST_TRAPPING);
  // nested ecall and stray mret fall through as no-ops
  assign take_trap = !freeze && ex_ecall && (state_q == ST_RUN);
  assign take_ret  = !freeze && ex_mret && (state_q == ST_TRAPPING);
  assign pc_load   = (!freeze && ex_redirect) || take_trap || take_ret;
  assign flush     = pc_load;
  assign pc_target = take_trap ? TRAP_VECTOR :
                     take_ret  ? epc_q + 32'd4 : ex_target;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state_q <= ST_RUN;
    end else if (take_trap) begin
      state_q <= ST_TRAPPING;
    end else if (take_ret) begin
      state_q <= ST_RUN;
    end
  end

  always_ff @(posedge clk) begin
    if (take_trap) begin
      epc_q <= ex_pc;
    end
  end

  // a redirect leaves a bubble in execute on the next cycle
  assert property (@(posedge clk) disable iff (!rst_n)
    pc_load |-> flush ##1 !(ex_redirect || ex_ecall || ex_mret));

  assert property (@(posedge clk) disable iff (!rst_n)
    freeze |=> $stable(trapping));

endmodule

//--- design/mini_core_execute.sv
`timescale 1ns/1ps

module mini_core_execute import core_pkg::*, ctrl_pkg::*; (
  input  logic      clk,
  input  logic      rst_n,
  input  logic      freeze,
  input  logic      flush,
  input  reg_addr_t rs1,
  input  reg_addr_t rs2,
  input  reg_addr_t rd,
  input  word_t     imm,
  input  alu_op_e   alu_op,
  input  logic      alu_src_imm,
  input  logic      mem_read,
  input  logic      mem_write,
  input  logic      reg_write,
  input  wb_src_e   wb_src,
  input  logic      is_branch,
  input  logic      branch_ne,
  input  logic      is_jal,
  input  logic      is_ecall,
  input  logic      is_mret,
  input  word_t     id_pc,
  input  word_t     rs1_data,
  input  word_t     rs2_data,
  input  logic      wb_we,
  input  reg_addr_t wb_rd,
  input  word_t     wb_data,
  output logic      ex_redirect,
  output word_t     ex_target,
  output logic      ex_ecall,
  output logic      ex_mret,
  output word_t     ex_pc,
  output word_t     ex_result,
  output reg_addr_t ex_rd,
  output logic      ex_reg_write,
  output wb_src_e   ex_wb_src,
  output word_t     dmem_addr,
  output word_t     dmem_wdata,
  output logic      dmem_we,
  output logic      dmem_re
);

  reg_addr_t rs1_q, rs2_q;
  word_t     imm_q, op1_q, op2_q;
  alu_op_e   alu_op_q;
  logic      alu_src_imm_q;
  logic      mem_read_q, mem_write_q, is_branch_q, branch_ne_q, is_jal_q;
  word_t     op_a, op_b, src_b, alu_res;
  logic      equal;

  ////////////////////////////////////////////////////////////////////////////
  // decode to execute register
  ////////////////////////////////////////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      {mem_read_q, mem_write_q, ex_reg_write} <= '0;
      {is_branch_q, is_jal_q, ex_ecall, ex_mret} <= '0;
    end else if (!freeze) begin
      mem_read_q   <= mem_read && !flush;
      mem_write_q  <= mem_write && !flush;
      ex_reg_write <= reg_write && !flush;
      is_branch_q  <= is_branch && !flush;
      is_jal_q     <= is_jal && !flush;
      ex_ecall     <= is_ecall && !flush;
      ex_mret      <= is_mret && !flush;
    end
  end

  always_ff @(posedge clk) begin
    if (!freeze) begin
      rs1_q         <= rs1;
      rs2_q         <= rs2;
      ex_rd         <= rd;
      imm_q         <= imm;
      op1_q         <= rs1_data;
      op2_q         <= rs2_data;
      alu_op_q      <= alu_op;
      alu_src_imm_q <= alu_src_imm;
      ex_wb_src     <= wb_src;
      branch_ne_q   <= branch_ne;
      ex_pc         <= id_pc;
    end
  end

  // writeback forwarding
  assign op_a  = (wb_we && wb_rd == rs1_q) ? wb_data : op1_q;
  assign op_b  = (wb_we && wb_rd == rs2_q) ? wb_data : op2_q;
  assign src_b = alu_src_imm_q ? imm_q : op_b;

  always_comb begin
    case (alu_op_q)
      ALU_SUB:    alu_res = op_a - src_b;
      ALU_AND:    alu_res = op_a & src_b;
      ALU_OR:     alu_res = op_a | src_b;
      ALU_XOR:    alu_res = op_a ^ src_b;
      ALU_SLT:    alu_res = word_t'($signed(op_a) < $signed(src_b));
      ALU_PASS_B: alu_res = src_b;
      default:    alu_res = op_a + src_b;
    endcase
  end

  // branch compare and target
  assign equal       = (op_a == op_b);
  assign ex_redirect = is_jal_q || (is_branch_q && (equal ^ branch_ne_q));
  assign ex_target   = ex_pc + imm_q;
  assign ex_result   = (ex_wb_src == WB_LINK) ? ex_pc + 32'd4 : alu_res;

  // data memory request
  assign dmem_addr  = alu_res;
  assign dmem_wdata = op_b;
  assign dmem_we    = mem_write_q && !freeze;
  assign dmem_re    = mem_read_q && !freeze;

endmodule

//--- design/mini_core_fetch.sv
`timescale 1ns/1ps

module mini_core_fetch import core_pkg::*; (
  input  logic   clk,
  input  logic   rst_n,
  input  logic   freeze,
  input  logic   flush,
  input  logic   pc_load,
  input  word_t  pc_target,
  input  instr_t imem_data,
  output word_t  imem_addr,
  output instr_t id_instr,
  output word_t  id_pc
);

  word_t pc_q;

  assign imem_addr = pc_q;

  // program counter
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      pc_q <= RESET_PC;
    end else if (!freeze) begin
      pc_q <= pc_load ? pc_target : pc_q + 32'd4;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // fetch to decode register
  ////////////////////////////////////////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      id_instr <= NOP_INSTR;
      id_pc    <= RESET_PC;
    end else if (!freeze) begin
      // the wrong-path word becomes a nop
      id_instr <= flush ? NOP_INSTR : imem_data;
      id_pc    <= pc_q;
    end
  end

endmodule

//--- design/mini_core_regfile.sv
`timescale 1ns/1ps

module mini_core_regfile import core_pkg::*; (
  input  logic      clk,
  input  logic      rst_n,
  input  logic      debug,
  input  reg_addr_t debug_addr,
  input  reg_addr_t rs1,
  input  reg_addr_t rs2,
  input  logic      wb_we,
  input  reg_addr_t wb_rd,
  input  word_t     wb_data,
  output word_t     rs1_data,
  output word_t     rs2_data
);

  word_t     regs [1:31];
  reg_addr_t rd_addr1;

  // debug steals read port 1
  assign rd_addr1 = debug ? debug_addr : rs1;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      for (int i = 1; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (wb_we && wb_rd != '0) begin
      regs[wb_rd] <= wb_data;
    end
  end

  // x0 reads zero and a matching write passes straight through
  assign rs1_data = (rd_addr1 == '0) ? '0 :
                    (wb_we && wb_rd == rd_addr1) ? wb_data : regs[rd_addr1];
  assign rs2_data = (rs2 == '0) ? '0 :
                    (wb_we && wb_rd == rs2) ? wb_data : regs[rs2];

  assert property (@(posedge clk) disable iff (!rst_n) debug |-> !wb_we);

endmodule

//--- design/mini_core_writeback.sv
`timescale 1ns/1ps

module mini_core_writeback import core_pkg::*, ctrl_pkg::*; (
  input  logic      clk,
  input  logic      rst_n,
  input  logic      freeze,
  input  word_t     ex_result,
  input  reg_addr_t ex_rd,
  input  logic      ex_reg_write,
  input  wb_src_e   ex_wb_src,
  input  word_t     dmem_rdata,
  output logic      wb_we,
  output reg_addr_t wb_rd,
  output word_t     wb_data
);

  logic    reg_write_q;
  logic    held_q;
  word_t   result_q;
  word_t   rdata_q;
  wb_src_e wb_src_q;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      reg_write_q <= 1'b0;
      held_q      <= 1'b0;
    end else begin
      held_q <= freeze;
      if (!freeze) begin
        // x0 writes dropped here
        reg_write_q <= ex_reg_write && (ex_rd != '0);
      end
    end
  end

  always_ff @(posedge clk) begin
    if (!freeze) begin
      wb_rd    <= ex_rd;
      result_q <= ex_result;
      wb_src_q <= ex_wb_src;
    end
    // memory answers once, keep it across a freeze
    if (!held_q) begin
      rdata_q <= dmem_rdata;
    end
  end

  assign wb_we   = reg_write_q && !freeze;
  assign wb_data = (wb_src_q != WB_MEM) ? result_q :
                   held_q ? rdata_q : dmem_rdata;

endmodule

//--- mini_core.f
+incdir+include
design/core_pkg.sv
design/ctrl_pkg.sv
design/mini_core_ctrl.sv
design/mini_core_fetch.sv
design/mini_core_regfile.sv
design/mini_core_execute.sv
design/mini_core_writeback.sv
design/mini_core.sv
verification/mini_core_tb.sv

//--- include/mini_core_prog.svh
`ifndef MINI_CORE_PROG_SVH
`define MINI_CORE_PROG_SVH

// main program, loaded from address 0
localparam int PROG_LEN = 23;
localparam logic [31:0] PROG [PROG_LEN] = '{
  32'h00500093, 32'h00700113, 32'h002081B3, 32'h40110233,  // x1..x4
  32'h0020F2B3, 32'h0020E333, 32'h0020C3B3, 32'h0020A433,  // and or xor slt
  32'h123454B7, 32'h00302823, 32'h01002503, 32'h001505B3,  // lui sw lw add
  32'h00108663, 32'h00102A23, 32'h06300613,                // beq + shadow
  32'h00109463, 32'h008006EF, 32'h00100713, 32'h00000073,  // bne jal ecall
  32'h00F02C23, 32'h0000006F, 32'h00000013, 32'h00000013   // sw halt
};

// trap handler, loaded at TRAP_VECTOR
localparam int HANDLER_LEN = 5;
localparam logic [31:0] HANDLER [HANDLER_LEN] = '{
  32'h00378793, 32'h00000073, 32'h30200073, 32'h00000013, 32'h00000013
};

localparam logic [31:0] ECALL_PC = 32'h0000_0048;
localparam logic [31:0] HALT_PC  = 32'h0000_0050;

// entry 0 is the pc seen in decode at the halt loop
localparam logic [31:0] EXP_REGS [32] = '{
  HALT_PC, 32'd5, 32'd7, 32'd12, 32'd2, 32'd5, 32'd7, 32'd2,
  32'd1, 32'h12345000, 32'd12, 32'd17, 32'd0, 32'h44, 32'd0, 32'd3,
  32'd0, 32'd0, 32'd0, 32'd0, 32'd0, 32'd0, 32'd0, 32'd0,
  32'd0, 32'd0, 32'd0, 32'd0, 32'd0, 32'd0, 32'd0, 32'd0
};

// expected stores in order, the beq shadow store is absent
localparam int STORE_COUNT = 2;
localparam logic [31:0] STORE_ADDR [STORE_COUNT] = '{32'h10, 32'h18};
localparam logic [31:0] STORE_DATA [STORE_COUNT] = '{32'd12, 32'd3};

`endif

//--- verification/mini_core_tb.sv
`timescale 1ns/1ps

module mini_core_tb import core_pkg::*; ();

  `include "mini_core_prog.svh"

  localparam int     IMEM_WORDS  = 128;
  localparam int     DMEM_WORDS  = 64;
  localparam int     PULSE_COUNT = 6;
  localparam int     MAX_GAP     = 8;
  localparam int     MAX_PULSE   = 3;
  localparam instr_t ECALL_WORD  = 32'h0000_0073;
  // program, handler, sweep and idle gaps times a margin of 4
  localparam int WATCHDOG_CYCLES =
    4 * (PROG_LEN + HANDLER_LEN + 32 + PULSE_COUNT * (MAX_GAP + 2 + MAX_PULSE));

  logic      clk;
  logic      rst_n;
  word_t     imem_addr;
  instr_t    imem_data;
  word_t     dmem_addr;
  word_t     dmem_wdata;
  logic      dmem_we;
  logic      dmem_re;
  word_t     dmem_rdata;
  logic      debug;
  reg_addr_t debug_addr;
  word_t     debug_data;
  logic      trapping;

  instr_t    imem [IMEM_WORDS];
  word_t     dmem [DMEM_WORDS];
  integer    seed;
  logic      sweep_on;
  logic      sweep_q;
  reg_addr_t last_addr;
  int        store_idx;
  int        sweep_reads;
  int        trap_entries;
  logic      trap_q;
  logic      ecall_seen;
  word_t     ecall_pc;

  mini_core i_mini_core (
    .clk, .rst_n, .imem_addr, .imem_data, .dmem_addr, .dmem_wdata, .dmem_we,
    .dmem_re, .dmem_rdata, .debug, .debug_addr, .debug_data, .trapping
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  task automatic stop_with_failure();
    $display("TEST FAILED");
    $fatal(1, "simulation stopped on the first error");
  endtask

  task automatic report_problem(input string why);
    $display("%s at %0t ns", why, $time);
    stop_with_failure();
  endtask

  task automatic report_mismatch(input string name, input word_t got, input word_t exp);
    $display("ERROR at %0t ns: %s is %h, expected %h", $time, name, got, exp);
    stop_with_failure();
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // memory models
  ////////////////////////////////////////////////////////////////////////////
  initial begin
    // unused words hold an unknown opcode tagged with their index
    for (int i = 0; i < IMEM_WORDS; i++) begin
      imem[i] = {25'(i), 7'h7f};
    end
    for (int i = 0; i < PROG_LEN; i++) begin
      imem[(RESET_PC >> 2) + i] = PROG[i];
    end
    for (int i = 0; i < HANDLER_LEN; i++) begin
      imem[(TRAP_VECTOR >> 2) + i] = HANDLER[i];
    end
    for (int i = 0; i < DMEM_WORDS; i++) begin
      dmem[i] = 32'h5a5a_0000 | i;
    end
    dmem_rdata = '0;
  end

  assign imem_data = imem[imem_addr[8:2]];

  always @(posedge clk) begin
    if (dmem_we) begin
      dmem[dmem_addr[7:2]] <= dmem_wdata;
    end
    if (dmem_re) begin
      dmem_rdata <= #2 dmem[dmem_addr[7:2]];
    end
  end

  // bookkeeping for the checks
  always @(posedge clk) begin
    if (!rst_n) begin
      store_idx    <= 0;
      sweep_reads  <= 0;
      trap_entries <= 0;
      trap_q       <= 1'b0;
      ecall_seen   <= 1'b0;
      sweep_q      <= 1'b0;
    end else begin
      if (dmem_we) begin
        store_idx <= store_idx + 1;
      end
      if (trapping && !trap_q) begin
        trap_entries <= trap_entries + 1;
      end
      trap_q <= trapping;
      // address of the first ecall fetched
      if (!ecall_seen && imem_data == ECALL_WORD) begin
        ecall_seen <= 1'b1;
        ecall_pc   <= imem_addr;
      end
      if (sweep_q) begin
        sweep_reads <= sweep_reads + 1;
      end
      sweep_q <= debug && sweep_on;
    end
    last_addr <= debug_addr;
  end

  ////////////////////////////////////////////////////////////////////////////
  // checking assertions
  ////////////////////////////////////////////////////////////////////////////
  assert property (@(posedge clk) !rst_n |=> (imem_addr == RESET_PC && !dmem_we &&
                                              !dmem_re && !trapping && debug_data == '0))
    else report_problem("outputs not in their reset state during or just after reset");

  assert property (@(posedge clk) disable iff (!rst_n)
    dmem_we |-> store_idx < STORE_COUNT)
    else report_problem("more stores than expected, a flushed store reached memory");

  assert property (@(posedge clk) disable iff (!rst_n)
    dmem_we && store_idx < STORE_COUNT |-> dmem_addr == STORE_ADDR[store_idx])
    else report_mismatch("dmem_addr", $sampled(dmem_addr),
                         STORE_ADDR[$sampled(store_idx)]);

  assert property (@(posedge clk) disable iff (!rst_n)
    dmem_we && store_idx < STORE_COUNT |-> dmem_wdata == STORE_DATA[store_idx])
    else report_mismatch("dmem_wdata", $sampled(dmem_wdata),
                         STORE_DATA[$sampled(store_idx)]);

  // trap entry and return
  assert property (@(posedge clk) disable iff (!rst_n)
    $rose(trapping) |-> imem_addr == TRAP_VECTOR)
    else report_mismatch("imem_addr", $sampled(imem_addr), TRAP_VECTOR);

  assert property (@(posedge clk) disable iff (!rst_n)
    $rose(trapping) |-> trap_entries == 0)
    else report_problem("trapping rose a second time, the nested ecall was taken");

  assert property (@(posedge clk) disable iff (!rst_n)
    $fell(trapping) |-> imem_addr == ecall_pc + 32'd4)
    else report_mismatch("imem_addr", $sampled(imem_addr), $sampled(ecall_pc) + 32'd4);

  // debug port
  assert property (@(posedge clk) disable iff (!rst_n)
    sweep_q |-> debug_data == EXP_REGS[last_addr])
    else report_mismatch("debug_data", $sampled(debug_data),
                         EXP_REGS[$sampled(last_addr)]);

  assert property (@(posedge clk) disable iff (!rst_n)
    !debug |=> debug_data == '0)
    else report_mismatch("debug_data", $sampled(debug_data), '0);

  // freeze
  assert property (@(posedge clk) disable iff (!rst_n)
    debug |=> $stable(imem_addr))
    else report_problem("imem_addr moved while debug was high");

  assert property (@(posedge clk) disable iff (!rst_n)
    debug |-> !dmem_we && !dmem_re)
    else report_problem("data memory was accessed while debug was high");

  ////////////////////////////////////////////////////////////////////////////
  // stimulus
  ////////////////////////////////////////////////////////////////////////////
  initial begin
    int gap;
    int hold;

    seed       = 95;
    rst_n      = 1'b0;
    debug      = 1'b0;
    debug_addr = '0;
    sweep_on   = 1'b0;
    repeat (3) @(posedge clk);
    #2 rst_n = 1'b1;

    // short freezes while the program runs
    for (int p = 0; p < PULSE_COUNT; p++) begin
      gap = 2 + ($unsigned($random(seed)) % MAX_GAP);
      repeat (gap) @(posedge clk);
      #2;
      debug      = 1'b1;
      debug_addr = reg_addr_t'($random(seed));
      hold = 1 + ($unsigned($random(seed)) % MAX_PULSE);
      repeat (hold) @(posedge clk);
      #2 debug = 1'b0;
    end

    // decode holds the halt jal while fetch is one word past it
    while (!(store_idx == STORE_COUNT && imem_addr == HALT_PC + 32'd4)) begin
      @(posedge clk);
      #2;
    end

    debug      = 1'b1;
    sweep_on   = 1'b1;
    debug_addr = '0;
    for (int a = 1; a < 32; a++) begin
      @(posedge clk);
      #2 debug_addr = reg_addr_t'(a);
    end
    @(posedge clk);
    #2;
    debug    = 1'b0;
    sweep_on = 1'b0;
    repeat (4) @(posedge clk);

    assert (store_idx == STORE_COUNT)
      else report_problem("store count differs from the expected store list");
    assert (sweep_reads == 32)
      else report_problem("debug sweep did not read all 32 registers");
    assert (trap_entries == 1 && !trapping)
      else report_problem("trap was not entered once and left again");
    assert (ecall_pc == ECALL_PC)
      else report_mismatch("ecall_pc", ecall_pc, ECALL_PC);

    $display("TEST PASSED");
    $finish;
  end

  // watchdog
  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    report_problem("watchdog expired before the program and the debug sweep finished");
  end

endmodule
